// ==== design/isa_pkg.sv ====
// instruction set definitions shared by every pipeline stage and the testbench
package isa_pkg;

    // datapath and address width
    localparam int word_w = 32;
    // register 0 is hardwired to zero
    localparam int reg_cnt = 16;
    localparam int reg_idx_w = $clog2(reg_cnt);
    localparam int imm_w = 16;

    typedef logic [word_w-1:0] word_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // 4-bit opcode field, unlisted codes behave as nop
    typedef enum logic [3:0] {
        op_nop  = 4'h0,
        op_add  = 4'h1,
        op_sub  = 4'h2,
        op_and  = 4'h3,
        op_or   = 4'h4,
        op_xor  = 4'h5,
        op_addi = 4'h6,
        op_lw   = 4'h7,
        op_sw   = 4'h8,
        op_beq  = 4'h9,
        op_halt = 4'ha
    } opcode_e;

    // instruction word, opcode in the top nibble
    typedef struct packed {
        opcode_e                 opcode;
        reg_idx_t                rd;
        reg_idx_t                rs1;
        reg_idx_t                rs2;
        logic signed [imm_w-1:0] imm;
    } instr_t;

    // immediate to full word, used for addresses, addi and branch offsets
    function automatic word_t sext_imm(input logic [imm_w-1:0] imm);
        return {{(word_w - imm_w){imm[imm_w-1]}}, imm};
    endfunction

endpackage

// ==== design/pipeline_pkg.sv ====
// pipeline latch and memory port structs, used by the datapath blocks and the testbench
package pipeline_pkg;

    // fetch to dispatch
    typedef struct packed {
        logic             valid;
        isa_pkg::word_t   pc;
        isa_pkg::instr_t  instr;
    } fd_t;

    // issue to execute, operands already read
    typedef struct packed {
        logic              valid;
        isa_pkg::word_t    pc;
        isa_pkg::opcode_e  opcode;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    rdat1;
        isa_pkg::word_t    rdat2;
        // sign extended at issue
        isa_pkg::word_t    imm;
        logic              writes_reg;
    } ie_t;

    // execute to writeback
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    wdata;
        logic              writes_reg;
        logic              halt;
    } ew_t;

    // instruction memory, request held until ihit
    typedef struct packed {
        logic           ren;
        isa_pkg::word_t addr;
    } imem_req_t;

    typedef struct packed {
        logic           ihit;
        isa_pkg::word_t load;
    } imem_rsp_t;

    // data memory, ren and wen never together
    typedef struct packed {
        logic           ren;
        logic           wen;
        isa_pkg::word_t addr;
        isa_pkg::word_t store;
    } dmem_req_t;

    typedef struct packed {
        logic           dhit;
        isa_pkg::word_t load;
    } dmem_rsp_t;

endpackage

// ==== design/fetch.sv ====
// fetch stage: program counter and instruction memory request, instantiated by sc_datapath
`timescale 1ns/10ps

module fetch (
    input  logic                    CLK,
    input  logic                    nrst,
    input  pipeline_pkg::imem_rsp_t imem_rsp,
    input  logic                    freeze,
    input  logic                    flush,
    input  isa_pkg::word_t          redirect_pc,
    input  logic                    halted,
    output pipeline_pkg::imem_req_t imem_req,
    output pipeline_pkg::fd_t       fd
);
    import isa_pkg::*;

    word_t pc_q;
    logic  accept;

    // a hit only counts when dispatch can take it
    // and the word is not on a killed path
    assign accept = imem_req.ren && imem_rsp.ihit && !freeze && !flush;

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc_q <= '0;
        end else if (flush) begin
            // branch taken in execute, restart at target
            pc_q <= redirect_pc;
        end else if (accept) begin
            pc_q <= pc_q + word_t'(1);
        end
    end

    // keep requesting until halt seen
    // on freeze the same pc is asked again
    assign imem_req.ren  = !halted;
    assign imem_req.addr = pc_q;

    // word to the fd latch
    assign fd.valid = accept;
    assign fd.pc    = pc_q;
    assign fd.instr = instr_t'(imem_rsp.load);

endmodule

// ==== design/scoreboard.sv ====
// scoreboard control block: decode, busy tracking, freeze and issue into the ie latch
`timescale 1ns/10ps

module scoreboard (
    input  logic              CLK,
    input  logic              nrst,
    input  pipeline_pkg::fd_t fd,
    input  pipeline_pkg::ew_t ew,
    input  isa_pkg::word_t    rdat1,
    input  isa_pkg::word_t    rdat2,
    input  logic              stall,
    input  logic              flush,
    output isa_pkg::reg_idx_t rsel1,
    output isa_pkg::reg_idx_t rsel2,
    output pipeline_pkg::ie_t ie,
    output logic              freeze,
    output logic              halted
);
    import isa_pkg::*;

    instr_t             instr;
    logic               use1;
    logic               use2;
    logic               writes;
    logic [reg_cnt-1:0] busy_q;
    logic [reg_cnt-1:0] busy_eff;
    logic [reg_cnt-1:0] wb_mask;
    logic [reg_cnt-1:0] set_mask;
    logic               hazard;
    logic               issue;
    logic               halt_pend_q;
    logic               halted_q;

    assign instr = fd.instr;
    assign rsel1 = instr.rs1;
    assign rsel2 = instr.rs2;

    // which operands are read, whether rd is written
    always_comb begin
        use1   = 1'b0;
        use2   = 1'b0;
        writes = 1'b0;
        case (instr.opcode)
            op_add, op_sub, op_and, op_or, op_xor: begin
                use1   = 1'b1;
                use2   = 1'b1;
                writes = 1'b1;
            end
            op_addi, op_lw: begin
                use1   = 1'b1;
                writes = 1'b1;
            end
            op_sw, op_beq: begin
                use1 = 1'b1;
                use2 = 1'b1;
            end
            default: begin
            end
        endcase
        // writes to r0 are dropped, so r0 never goes busy
        if (instr.rd == '0) begin
            writes = 1'b0;
        end
    end

    // register retiring this cycle is readable through the regfile bypass
    always_comb begin
        wb_mask = '0;
        if (ew.valid && ew.writes_reg) begin
            wb_mask[ew.rd] = 1'b1;
        end
    end

    assign busy_eff = busy_q & ~wb_mask;

    // RAW on sources, WAW on destination
    assign hazard = fd.valid && ((use1 && busy_eff[instr.rs1]) ||
                                 (use2 && busy_eff[instr.rs2]) ||
                                 (writes && busy_eff[instr.rd]));

    // nothing issues behind a halt
    assign freeze = hazard || stall || halt_pend_q;
    assign issue  = fd.valid && !freeze && !flush;

    always_comb begin
        set_mask = '0;
        if (issue && writes) begin
            set_mask[instr.rd] = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            busy_q      <= '0;
            halt_pend_q <= 1'b0;
            halted_q    <= 1'b0;
        end else begin
            busy_q      <= busy_eff | set_mask;
            halt_pend_q <= halt_pend_q || (issue && instr.opcode == op_halt);
            halted_q    <= halted;
        end
    end

    // high from the cycle halt sits in the ew latch, sticky afterwards
    assign halted = halted_q || (ew.valid && ew.halt);

    // issue slot, bubble when frozen or flushed
    assign ie.valid      = issue;
    assign ie.pc         = fd.pc;
    assign ie.opcode     = instr.opcode;
    assign ie.rd         = instr.rd;
    assign ie.rdat1      = rdat1;
    assign ie.rdat2      = rdat2;
    assign ie.imm        = sext_imm(instr.imm);
    assign ie.writes_reg = writes;

endmodule

// ==== design/regfile.sv ====
// register file with sixteen 32-bit entries, written from the ew latch, used by sc_datapath
`timescale 1ns/10ps

module regfile (
    input  logic              CLK,
    input  logic              nrst,
    input  isa_pkg::reg_idx_t rsel1,
    input  isa_pkg::reg_idx_t rsel2,
    input  pipeline_pkg::ew_t ew,
    output isa_pkg::word_t    rdat1,
    output isa_pkg::word_t    rdat2
);
    import isa_pkg::*;

    word_t regs [reg_cnt];
    logic  wen;

    // r0 is never stored
    assign wen = ew.valid && ew.writes_reg && (ew.rd != '0);

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < reg_cnt; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[ew.rd] <= ew.wdata;
        end
    end

    // write-through so issue sees the retiring value in the same cycle
    always_comb begin
        rdat1 = regs[rsel1];
        rdat2 = regs[rsel2];
        if (wen && ew.rd == rsel1) begin
            rdat1 = ew.wdata;
        end
        if (wen && ew.rd == rsel2) begin
            rdat2 = ew.wdata;
        end
        if (rsel1 == '0) begin
            rdat1 = '0;
        end
        if (rsel2 == '0) begin
            rdat2 = '0;
        end
    end

endmodule

// ==== design/execute.sv ====
// execute stage of sc_datapath with ALU, branch resolve, data access and writeback select
`timescale 1ns/10ps

module execute (
    input  logic                    CLK,
    input  logic                    nrst,
    input  pipeline_pkg::ie_t       ie,
    input  pipeline_pkg::dmem_rsp_t dmem_rsp,
    output pipeline_pkg::dmem_req_t dmem_req,
    output pipeline_pkg::ew_t       ew,
    output logic                    stall,
    output logic                    flush,
    output isa_pkg::word_t          redirect_pc
);
    import isa_pkg::*;

    word_t alu_res;
    logic  is_ld;
    logic  is_st;

    assign is_ld = ie.valid && ie.opcode == op_lw;
    assign is_st = ie.valid && ie.opcode == op_sw;

    // add and sub wrap
    always_comb begin
        case (ie.opcode)
            op_add:  alu_res = ie.rdat1 + ie.rdat2;
            op_sub:  alu_res = ie.rdat1 - ie.rdat2;
            op_and:  alu_res = ie.rdat1 & ie.rdat2;
            op_or:   alu_res = ie.rdat1 | ie.rdat2;
            op_xor:  alu_res = ie.rdat1 ^ ie.rdat2;
            op_addi: alu_res = ie.rdat1 + ie.imm;
            default: alu_res = '0;
        endcase
    end

    // address is rs1 + imm and store data comes from rs2
    // the ie latch holds through a stall and keeps the request steady until dhit
    assign dmem_req.ren   = is_ld;
    assign dmem_req.wen   = is_st;
    assign dmem_req.addr  = ie.rdat1 + ie.imm;
    assign dmem_req.store = ie.rdat2;
    assign stall          = (is_ld || is_st) && !dmem_rsp.dhit;

    // beq resolved here with the target relative to pc + 1
    assign flush       = ie.valid && ie.opcode == op_beq && ie.rdat1 == ie.rdat2;
    assign redirect_pc = ie.pc + word_t'(1) + ie.imm;

    // retire only once the memory access is done
    assign ew.valid      = ie.valid && !stall;
    assign ew.rd         = ie.rd;
    assign ew.wdata      = is_ld ? dmem_rsp.load : alu_res;
    assign ew.writes_reg = ie.writes_reg;
    assign ew.halt       = ie.opcode == op_halt;

endmodule

// ==== design/sc_datapath.sv ====
// top level of the scoreboarded pipeline: stage instances, latches and memory ports
`timescale 1ns/10ps

module sc_datapath (
    input  logic                    CLK,
    input  logic                    nrst,
    output pipeline_pkg::imem_req_t imem_req,
    input  pipeline_pkg::imem_rsp_t imem_rsp,
    output pipeline_pkg::dmem_req_t dmem_req,
    input  pipeline_pkg::dmem_rsp_t dmem_rsp,
    output logic                    halt
);
    import isa_pkg::*;
    import pipeline_pkg::*;

    // latch inputs and outputs
    fd_t      fd_fetch;
    fd_t      fd_q;
    ie_t      ie_issue;
    ie_t      ie_q;
    ew_t      ew_exec;
    ew_t      ew_q;

    reg_idx_t rsel1;
    reg_idx_t rsel2;
    word_t    rdat1;
    word_t    rdat2;
    word_t    redirect_pc;
    logic     freeze;
    logic     flush;
    logic     stall;
    logic     halted;

    fetch fetch_i (
        .CLK         (CLK),
        .nrst        (nrst),
        .imem_rsp    (imem_rsp),
        .freeze      (freeze),
        .flush       (flush),
        .redirect_pc (redirect_pc),
        .halted      (halted),
        .imem_req    (imem_req),
        .fd          (fd_fetch)
    );

    scoreboard scoreboard_i (
        .CLK    (CLK),
        .nrst   (nrst),
        .fd     (fd_q),
        .ew     (ew_q),
        .rdat1  (rdat1),
        .rdat2  (rdat2),
        .stall  (stall),
        .flush  (flush),
        .rsel1  (rsel1),
        .rsel2  (rsel2),
        .ie     (ie_issue),
        .freeze (freeze),
        .halted (halted)
    );

    regfile regfile_i (
        .CLK   (CLK),
        .nrst  (nrst),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .ew    (ew_q),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    execute execute_i (
        .CLK         (CLK),
        .nrst        (nrst),
        .ie          (ie_q),
        .dmem_rsp    (dmem_rsp),
        .dmem_req    (dmem_req),
        .ew          (ew_exec),
        .stall       (stall),
        .flush       (flush),
        .redirect_pc (redirect_pc)
    );

    // fd holds on any freeze
    // ie holds only while execute waits, hazard freezes feed it a bubble
    // flush kills both younger slots
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            fd_q <= '0;
            ie_q <= '0;
            ew_q <= '0;
        end else begin
            if (flush) begin
                fd_q <= '0;
            end else if (!freeze) begin
                fd_q <= fd_fetch;
            end
            if (flush) begin
                ie_q <= '0;
            end else if (!stall) begin
                ie_q <= ie_issue;
            end
            // execute sends a bubble while stalled
            ew_q <= ew_exec;
        end
    end

    assign halt = halted;

endmodule

// ==== sim/sc_datapath_properties.sv ====
// concurrent checks on the data memory port and halt output that are bound into sc_datapath
`timescale 1ns/10ps

module sc_datapath_properties (
    input logic                    CLK,
    input logic                    nrst,
    input pipeline_pkg::dmem_req_t dmem_req,
    input pipeline_pkg::dmem_rsp_t dmem_rsp,
    input logic                    halt
);

    // running count of failed properties
    int viol_cnt = 0;

    // one access kind at a time
    a_rw_excl: assert property (@(posedge CLK) disable iff (!nrst)
        !(dmem_req.ren && dmem_req.wen))
        else begin
            $error("data memory read and write requested together");
            viol_cnt++;
        end

    // pending access holds its request until dhit
    a_req_stable: assert property (@(posedge CLK) disable iff (!nrst)
        (dmem_req.ren || dmem_req.wen) && !dmem_rsp.dhit |=>
            $stable(dmem_req.ren) && $stable(dmem_req.wen) &&
            $stable(dmem_req.addr) && $stable(dmem_req.store))
        else begin
            $error("data memory request changed before dhit");
            viol_cnt++;
        end

    // sticky until reset
    a_halt_sticky: assert property (@(posedge CLK) disable iff (!nrst)
        halt |=> halt)
        else begin
            $error("halt dropped without reset");
            viol_cnt++;
        end

endmodule

bind sc_datapath sc_datapath_properties props_i (
    .CLK      (CLK),
    .nrst     (nrst),
    .dmem_req (dmem_req),
    .dmem_rsp (dmem_rsp),
    .halt     (halt)
);

// ==== sim/sc_datapath_tb.sv ====
// top-level testbench that runs directed and random programs on sc_datapath against a model
`timescale 1ns/10ps

module sc_datapath_tb;
    import isa_pkg::*;
    import pipeline_pkg::*;

    localparam int          halt_limit = 3000;
    localparam logic [15:0] lfsr_seed  = 16'd14648;

    logic        CLK;
    logic        nrst;
    imem_req_t   imem_req;
    imem_rsp_t   imem_rsp;
    dmem_req_t   dmem_req;
    dmem_rsp_t   dmem_rsp;
    logic        halt;

    word_t       rom [256];
    word_t       ram [256];
    word_t       exp_ram [256];
    int          prog_len;
    logic [15:0] lfsr;
    bit          rst_seen;
    bit          rst_hold;
    bit          i_armed;
    bit          d_armed;
    int          i_cnt;
    int          d_cnt;
    logic        ihit_now;
    logic        dhit_now;
    int          err_cnt;
    int          err_at_start;
    int          test_cnt;
    int          fail_cnt;

    sc_datapath dut_i (
        .CLK      (CLK),
        .nrst     (nrst),
        .imem_req (imem_req),
        .imem_rsp (imem_rsp),
        .dmem_req (dmem_req),
        .dmem_rsp (dmem_rsp),
        .halt     (halt)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #10 CLK = ~CLK;
        end
    end

    // taps for x^16 + x^14 + x^13 + x^11
    // new bit enters at bit 0
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    // data ram fill that differs for every address
    function automatic word_t fill_word(input int a);
        return 32'h5a5a_0000 ^ (word_t'(a) * 32'h0001_0203);
    endfunction

    function automatic word_t enc(input opcode_e op, input logic [3:0] rd,
                                  input logic [3:0] rs1, input logic [3:0] rs2,
                                  input logic [15:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    task automatic put(input opcode_e op, input int rd, input int rs1, input int rs2,
                       input int imm);
        rom[prog_len] = enc(op, rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]);
        prog_len++;
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // latency of 0..3 cycles drawn when a request is first seen
    task automatic hit_turn(input logic active, inout bit armed, inout int cnt,
                            output logic hit);
        logic [31:0] lat;
        hit = 1'b0;
        if (!active) begin
            armed = 1'b0;
        end else begin
            if (!armed) begin
                draw(2, lat);
                cnt   = lat;
                armed = 1'b1;
            end
            if (cnt == 0) begin
                hit   = 1'b1;
                armed = 1'b0;
            end else begin
                cnt--;
            end
        end
    endtask

    // instruction rom and data ram answering 2 ns after the edge
    always @(posedge CLK) begin
        rst_seen = nrst;
        #2;
        if (!rst_seen || rst_hold) begin
            imem_rsp = '0;
            dmem_rsp = '0;
            i_armed  = 1'b0;
            d_armed  = 1'b0;
        end else begin
            hit_turn(imem_req.ren, i_armed, i_cnt, ihit_now);
            imem_rsp.ihit = ihit_now;
            imem_rsp.load = ihit_now ? rom[imem_req.addr[7:0]] : '0;
            hit_turn(dmem_req.ren || dmem_req.wen, d_armed, d_cnt, dhit_now);
            dmem_rsp.dhit = dhit_now;
            dmem_rsp.load = (dhit_now && dmem_req.ren) ? ram[dmem_req.addr[7:0]] : '0;
            if (dhit_now && dmem_req.wen) begin
                ram[dmem_req.addr[7:0]] = dmem_req.store;
            end
        end
    end

    // unused rom words are halts tagged with their address
    task automatic load_program();
        for (int a = 0; a < 256; a++) begin
            rom[a] = enc(op_halt, '0, '0, '0, a[15:0]);
            ram[a] = fill_word(a);
        end
        prog_len = 0;
    endtask

    // ISA rules applied in program order on a copy of the ram
    task automatic run_model();
        word_t r [reg_cnt];
        word_t pc;
        word_t w;
        word_t imm;
        word_t a;
        word_t val;
        logic  wr;
        logic  done;
        int    steps;
        for (int i = 0; i < 256; i++) begin
            exp_ram[i] = ram[i];
        end
        for (int i = 0; i < reg_cnt; i++) begin
            r[i] = '0;
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 4096) begin
            w   = rom[pc[7:0]];
            imm = {{16{w[15]}}, w[15:0]};
            a   = r[w[23:20]] + imm;
            wr  = 1'b1;
            val = '0;
            pc  = pc + 1;
            case (w[31:28])
                op_add:  val = r[w[23:20]] + r[w[19:16]];
                op_sub:  val = r[w[23:20]] - r[w[19:16]];
                op_and:  val = r[w[23:20]] & r[w[19:16]];
                op_or:   val = r[w[23:20]] | r[w[19:16]];
                op_xor:  val = r[w[23:20]] ^ r[w[19:16]];
                op_addi: val = a;
                op_lw:   val = exp_ram[a[7:0]];
                default: wr = 1'b0;
            endcase
            if (w[31:28] == op_sw) begin
                exp_ram[a[7:0]] = r[w[19:16]];
            end
            // target is own pc + 1 + imm
            if (w[31:28] == op_beq && r[w[23:20]] == r[w[19:16]]) begin
                pc = pc + imm;
            end
            done = (w[31:28] == op_halt);
            if (wr && w[27:24] != 0) begin
                r[w[27:24]] = val;
            end
            steps++;
        end
    endtask

    // memory model stays quiet from the edge where reset is applied
    task automatic reset_dut();
        rst_hold = 1'b1;
        @(posedge CLK);
        #2 nrst = 1'b0;
        repeat (10) @(posedge CLK);
        #2 nrst = 1'b1;
        rst_hold = 1'b0;
    endtask

    // reset, run until halt and compare the whole ram with the model
    task automatic run_program(input string name);
        int n;
        run_model();
        reset_dut();
        n = 0;
        while (!halt && n < halt_limit) begin
            @(negedge CLK);
            n++;
        end
        if (!halt) begin
            $display("timeout: halt never came within %0d cycles in test %s", halt_limit, name);
            err_cnt++;
        end else begin
            for (int a = 0; a < 256; a++) begin
                check_eq($sformatf("data word %0d", a), ram[a], exp_ram[a]);
            end
        end
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt != err_at_start) begin
            fail_cnt++;
            $display("test %-16s failed with %0d errors", name, err_cnt - err_at_start);
        end else begin
            $display("test %-16s ok", name);
        end
        err_at_start = err_cnt;
    endtask

    task automatic reset_values();
        load_program();
        reset_dut();
        @(negedge CLK);
        check_eq("halt after reset", halt, 1'b0);
        check_eq("dmem ren after reset", dmem_req.ren, 1'b0);
        check_eq("dmem wen after reset", dmem_req.wen, 1'b0);
        check_eq("imem ren after reset", imem_req.ren, 1'b1);
        check_eq("first fetch address", imem_req.addr, 32'd0);
        run_program("reset state");
        end_test("reset state");
    endtask

    // every result feeds the next instruction
    task automatic dependent_alu_chain();
        load_program();
        put(op_addi, 1, 0, 0, 5);
        put(op_addi, 2, 1, 0, 7);
        put(op_add, 3, 1, 2, 0);
        put(op_sub, 4, 3, 1, 0);
        put(op_or, 5, 4, 3, 0);
        put(op_xor, 6, 5, 2, 0);
        put(op_and, 7, 6, 3, 0);
        put(op_sub, 8, 1, 2, 0);
        put(op_addi, 9, 0, 0, -1);
        put(op_add, 10, 9, 9, 0);
        for (int k = 2; k <= 10; k++) begin
            put(op_sw, 0, 0, k, 14 + k);
        end
        put(op_halt, 0, 0, 0, 0);
        run_program("alu chain");
        check_eq("addi chain", ram[16], 32'd12);
        check_eq("add", ram[17], 32'd17);
        check_eq("or", ram[19], 32'd29);
        check_eq("and", ram[21], 32'd17);
        check_eq("sub wraps", ram[22], 32'hffff_fff9);
        check_eq("add wraps", ram[24], 32'hffff_fffe);
        end_test("alu chain");
    endtask

    task automatic load_store_round_trip();
        load_program();
        put(op_addi, 1, 0, 0, 40);
        put(op_lw, 2, 1, 0, 0);
        put(op_addi, 3, 2, 0, 1);
        put(op_sw, 0, 1, 3, 2);
        put(op_lw, 4, 1, 0, 2);
        put(op_xor, 5, 4, 2, 0);
        put(op_sw, 0, 1, 5, -1);
        put(op_sw, 0, 1, 4, 10);
        put(op_halt, 0, 0, 0, 0);
        run_program("load/store");
        check_eq("store after load", ram[42], fill_word(40) + 1);
        check_eq("negative offset", ram[39], (fill_word(40) + 1) ^ fill_word(40));
        check_eq("reload", ram[50], fill_word(40) + 1);
        end_test("load/store");
    endtask

    task automatic branch_skip_and_fall_through();
        load_program();
        put(op_addi, 1, 0, 0, 3);
        put(op_addi, 2, 0, 0, 3);
        // taken branch skips the store at pc 3
        put(op_beq, 0, 1, 2, 1);
        put(op_sw, 0, 0, 1, 60);
        put(op_addi, 3, 0, 0, 9);
        // not taken so it falls through
        put(op_beq, 0, 1, 3, 1);
        put(op_sw, 0, 0, 3, 61);
        put(op_halt, 0, 0, 0, 0);
        run_program("branches");
        check_eq("skipped store", ram[60], fill_word(60));
        check_eq("fall-through store", ram[61], 32'd9);
        end_test("branches");
    endtask

    // loads and stores use r0 as base, so addresses stay in 0..63
    task automatic random_program();
        logic [31:0] sel;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] ofs;
        logic [31:0] imm8;
        load_program();
        for (int k = 0; k < 48; k++) begin
            draw(3, sel);
            draw(3, rd);
            draw(3, rs1);
            draw(3, rs2);
            draw(6, ofs);
            draw(8, imm8);
            case (sel)
                0: put(op_add, rd, rs1, rs2, 0);
                1: put(op_sub, rd, rs1, rs2, 0);
                2: put(op_and, rd, rs1, rs2, 0);
                3: put(op_or, rd, rs1, rs2, 0);
                4: put(op_xor, rd, rs1, rs2, 0);
                5: put(op_addi, rd, rs1, 0, int'(imm8) - 128);
                6: put(op_lw, rd, 0, 0, ofs);
                default: put(op_sw, 0, 0, rs2, ofs);
            endcase
        end
        put(op_halt, 0, 0, 0, 0);
        run_program("random program");
        end_test("random program");
    endtask

    task automatic halt_stops_pipeline();
        load_program();
        put(op_addi, 1, 0, 0, 77);
        put(op_sw, 0, 0, 1, 70);
        put(op_halt, 0, 0, 0, 0);
        put(op_sw, 0, 0, 1, 71);
        put(op_sw, 0, 0, 1, 72);
        run_program("halt");
        check_eq("store before halt", ram[70], 32'd77);
        check_eq("store after halt", ram[71], fill_word(71));
        // halt holds and both memory ports stay quiet
        repeat (20) begin
            @(negedge CLK);
            check_eq("halt held", halt, 1'b1);
            check_eq("dmem wen after halt", dmem_req.wen, 1'b0);
            check_eq("imem ren after halt", imem_req.ren, 1'b0);
        end
        end_test("halt");
    endtask

    initial begin
        nrst         = 1'b0;
        imem_rsp     = '0;
        dmem_rsp     = '0;
        rst_hold     = 1'b0;
        lfsr         = lfsr_seed;
        err_cnt      = 0;
        err_at_start = 0;
        test_cnt     = 0;
        fail_cnt     = 0;
        reset_values();
        dependent_alu_chain();
        load_store_round_trip();
        branch_skip_and_fall_through();
        random_program();
        halt_stops_pipeline();
        if (dut_i.props_i.viol_cnt != 0) begin
            $display("property checks failed %0d times", dut_i.props_i.viol_cnt);
            err_cnt += dut_i.props_i.viol_cnt;
        end
        $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== project.f ====
design/isa_pkg.sv
design/pipeline_pkg.sv
design/fetch.sv
design/scoreboard.sv
design/regfile.sv
design/execute.sv
design/sc_datapath.sv
sim/sc_datapath_properties.sv
sim/sc_datapath_tb.sv

// ==== Bender.yml ====
package:
  name: sc_datapath

sources:
  - design/isa_pkg.sv
  - design/pipeline_pkg.sv
  - design/fetch.sv
  - design/scoreboard.sv
  - design/regfile.sv
  - design/execute.sv
  - design/sc_datapath.sv
  - target: simulation
    files:
      - sim/sc_datapath_properties.sv
      - sim/sc_datapath_tb.sv
